//--- design/uartPkg.sv
package uartPkg;

    // one received or forwarded byte
    typedef logic [7:0] byteT;

    // byte out of the receiver, valid for a single cycle
    typedef struct packed {
        byteT data;
        logic valid;
    } rxByteT;

    // receiver bit slots, one per bit of an 8N1 frame
    typedef enum logic [3:0] {
        slotIdle,   // waiting for a falling edge
        slotStart,  // inside the start bit
        slotBit0,
        slotBit1,
        slotBit2,
        slotBit3,
        slotBit4,
        slotBit5,
        slotBit6,
        slotBit7,
        slotStop
    } bitSlotT;

endpackage

//--- design/loaderPkg.sv
package loaderPkg;

    // header bytes 00 AA FF, first byte in the top bits
    localparam logic [23:0] headerId = 24'h00AAFF;

    // command codes in bits 6..0 that open a data phase
    localparam logic [6:0] cmdWriteA = 7'd1;
    localparam logic [6:0] cmdWriteB = 7'd2;

    // command bit set means ASCII hex data, clear means raw binary
    localparam int hexSelectBit = 7;

    typedef enum logic [2:0] {
        frameIdle,
        frameId0,
        frameId1,
        frameId2,
        frameCommand,
        frameEvaluate,  // single cycle
        frameData
    } frameStateT;

    // data byte towards the word assembler
    typedef struct packed {
        uartPkg::byteT value;
        logic          valid;
    } dataByteT;

    // finished word with its write strobe
    typedef struct packed {
        logic [31:0] data;
        logic        strobe;
    } cfgWordT;

endpackage

//--- design/uartRx.sv
module uartRx #(
    parameter int clocksPerBit = 217
) (
    input  logic            CLK,
    input  logic            resetn,
    input  logic            rx,
    output uartPkg::rxByteT rxByte,
    output logic            lineStart
);
    import uartPkg::*;

    localparam int countWidth = $clog2(clocksPerBit + 1);
    localparam logic [countWidth-1:0] fullPeriod = countWidth'(clocksPerBit - 1);
    localparam logic [countWidth-1:0] halfPeriod = countWidth'(clocksPerBit / 2 - 1);

    logic                  rxSync;
    logic [countWidth-1:0] bitCount;
    logic                  bitTick;
    bitSlotT               slot;
    byteT                  shiftReg;
    byteT                  rxData;
    logic                  rxValid;

    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            rxSync <= 1'b1;  // line idles high
        end else begin
            rxSync <= rx;
        end
    end

    assign lineStart = (slot == slotIdle) && !rxSync;
    assign bitTick   = (slot != slotIdle) && (bitCount == '0);

    // half period after the start edge puts every later tick in mid-bit
    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            bitCount <= halfPeriod;
        end else if (slot == slotIdle) begin
            bitCount <= halfPeriod;
        end else if (bitTick) begin
            bitCount <= fullPeriod;
        end else begin
            bitCount <= bitCount - 1'b1;
        end
    end

    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            slot    <= slotIdle;
            rxValid <= 1'b0;
        end else begin
            rxValid <= 1'b0;
            if (lineStart) begin
                slot <= slotStart;
            end else if (bitTick) begin
                if (slot == slotStop) begin
                    slot    <= slotIdle;  // back to hunting for a start bit
                    rxValid <= 1'b1;
                end else begin
                    slot <= bitSlotT'(slot + 1'b1);
                end
            end
        end
    end

    // lsb arrives first, so shift in from the top
    always_ff @(posedge CLK) begin
        if (bitTick && slot >= slotBit0 && slot <= slotBit7) begin
            shiftReg <= {rxSync, shiftReg[7:1]};
        end
        if (bitTick && slot == slotStop) begin
            rxData <= shiftReg;
        end
    end

    assign rxByte = '{data: rxData, valid: rxValid};

endmodule

//--- design/loaderControl.sv
module loaderControl #(
    parameter int timeoutCycles = 100000
) (
    input  logic              CLK,
    input  logic              resetn,
    input  uartPkg::rxByteT   rxByte,
    input  logic              lineStart,
    output uartPkg::byteT     command,
    output logic              comActive,
    output logic              hexEnable,
    output logic              frameStart,
    output loaderPkg::dataByteT binByte
);
    import uartPkg::*;
    import loaderPkg::*;

    localparam int timerWidth = $clog2(timeoutCycles + 1);
    localparam logic [timerWidth-1:0] timerLoad = timerWidth'(timeoutCycles);

    frameStateT            state;
    logic [23:0]           idReg;
    byteT                  commandReg;
    logic [timerWidth-1:0] quietCount;
    logic                  timedOut;
    logic                  headerOk;
    byteT                  binData;
    logic                  binValid;

    assign timedOut = (quietCount == '0);
    assign headerOk = (idReg == headerId) &&
                      (commandReg[6:0] == cmdWriteA || commandReg[6:0] == cmdWriteB);

    // any byte on the line restarts the quiet timer
    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            quietCount <= timerLoad;
        end else if (state == frameIdle || rxByte.valid) begin
            quietCount <= timerLoad;
        end else if (!timedOut) begin
            quietCount <= quietCount - 1'b1;
        end
    end

    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            state      <= frameIdle;
            commandReg <= '0;
        end else if (state != frameIdle && timedOut) begin
            state <= frameIdle;  // silence ends everything, the data phase included
        end else begin
            case (state)
                frameIdle: if (lineStart) state <= frameId0;
                frameId0:  if (rxByte.valid) state <= frameId1;
                frameId1:  if (rxByte.valid) state <= frameId2;
                frameId2:  if (rxByte.valid) state <= frameCommand;
                frameCommand: begin
                    if (rxByte.valid) begin
                        commandReg <= rxByte.data;
                        state      <= frameEvaluate;
                    end
                end
                frameEvaluate: state <= headerOk ? frameData : frameIdle;
                frameData: state <= frameData;  // left only by timeout
                default: state <= frameIdle;
            endcase
        end
    end

    // id bytes, first one ends up in the top bits
    always_ff @(posedge CLK) begin
        if (rxByte.valid) begin
            case (state)
                frameId0: idReg[23:16] <= rxByte.data;
                frameId1: idReg[15:8]  <= rxByte.data;
                frameId2: idReg[7:0]   <= rxByte.data;
                default:  idReg        <= idReg;
            endcase
        end
    end

    // raw binary bytes go out one cycle after the receiver pulse
    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            binValid <= 1'b0;
        end else begin
            binValid <= rxByte.valid && comActive && !commandReg[hexSelectBit];
        end
    end

    always_ff @(posedge CLK) begin
        if (rxByte.valid) begin
            binData <= rxByte.data;
        end
    end

    assign binByte    = '{value: binData, valid: binValid};
    assign command    = commandReg;
    assign comActive  = (state == frameData);
    assign hexEnable  = comActive && commandReg[hexSelectBit];
    assign frameStart = (state == frameEvaluate);

endmodule

//--- design/hexDecoder.sv
module hexDecoder (
    input  logic                CLK,
    input  logic                resetn,
    input  uartPkg::rxByteT     rxByte,
    input  logic                hexEnable,
    output loaderPkg::dataByteT hexByte
);
    import uartPkg::*;

    // bit 4 set marks a character that is not hex
    function automatic logic [4:0] asciiToNibble(input byteT c);
        logic [4:0] nibble;
        if (c >= 8'h30 && c <= 8'h39) begin
            nibble = {1'b0, c[3:0]};  // 0-9
        end else if ((c >= 8'h41 && c <= 8'h46) || (c >= 8'h61 && c <= 8'h66)) begin
            nibble = {1'b0, c[3:0] + 4'd9};  // A-F and a-f share the low bits
        end else begin
            nibble = 5'b10000;
        end
        return nibble;
    endfunction

    logic [4:0] nibble;
    logic       lowNext;     // next valid character is the low nibble
    logic [3:0] highNibble;
    byteT       hexData;
    logic       hexValid;

    assign nibble = asciiToNibble(rxByte.data);

    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            lowNext  <= 1'b0;
            hexValid <= 1'b0;
        end else begin
            hexValid <= 1'b0;
            if (!hexEnable) begin
                lowNext <= 1'b0;
            end else if (rxByte.valid) begin
                if (nibble[4]) begin
                    lowNext <= 1'b0;  // broken pair is dropped
                end else begin
                    lowNext  <= !lowNext;
                    hexValid <= lowNext;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (hexEnable && rxByte.valid && !nibble[4]) begin
            if (lowNext) begin
                hexData <= {highNibble, nibble[3:0]};
            end else begin
                highNibble <= nibble[3:0];
            end
        end
    end

    assign hexByte = '{value: hexData, valid: hexValid};

endmodule

//--- design/wordAssembler.sv
module wordAssembler (
    input  logic                CLK,
    input  logic                resetn,
    input  loaderPkg::dataByteT binByte,
    input  loaderPkg::dataByteT hexByte,
    input  logic                frameStart,
    output loaderPkg::cfgWordT  cfgWord
);
    import uartPkg::*;

    logic        byteValid;
    byteT        inByte;
    logic [1:0]  position;
    logic [23:0] partial;    // first three bytes of the word in progress
    logic [31:0] wordData;
    logic        wordStrobe;

    // only one stream is live per frame
    assign byteValid = binByte.valid || hexByte.valid;
    assign inByte    = binByte.valid ? binByte.value : hexByte.value;

    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            position   <= 2'd0;
            partial    <= '0;
            wordData   <= '0;
            wordStrobe <= 1'b0;
        end else begin
            wordStrobe <= 1'b0;
            if (frameStart) begin
                position <= 2'd0;
                partial  <= '0;
                wordData <= '0;
            end else if (byteValid) begin
                position <= position + 1'b1;
                case (position)
                    2'd0: partial[23:16] <= inByte;  // most significant first
                    2'd1: partial[15:8]  <= inByte;
                    2'd2: partial[7:0]   <= inByte;
                    default: begin
                        wordData   <= {partial, inByte};
                        wordStrobe <= 1'b1;
                    end
                endcase
            end
        end
    end

    assign cfgWord = '{data: wordData, strobe: wordStrobe};

endmodule

//--- design/cfgUartTop.sv
module cfgUartTop #(
    parameter int clocksPerBit  = 217,
    parameter int timeoutCycles = 100000
) (
    input  logic               CLK,
    input  logic               resetn,
    input  logic               rx,
    output loaderPkg::cfgWordT cfgWord,
    output uartPkg::byteT      command,
    output logic               comActive
);
    import uartPkg::*;
    import loaderPkg::*;

    rxByteT   rxByte;
    logic     lineStart;
    dataByteT binByte;
    dataByteT hexByte;
    logic     hexEnable;
    logic     frameStart;

    uartRx #(
        .clocksPerBit(clocksPerBit)
    ) uartRx0 (
        .CLK      (CLK),
        .resetn   (resetn),
        .rx       (rx),
        .rxByte   (rxByte),
        .lineStart(lineStart)
    );

    loaderControl #(
        .timeoutCycles(timeoutCycles)
    ) loaderControl0 (
        .CLK       (CLK),
        .resetn    (resetn),
        .rxByte    (rxByte),
        .lineStart (lineStart),
        .command   (command),
        .comActive (comActive),
        .hexEnable (hexEnable),
        .frameStart(frameStart),
        .binByte   (binByte)
    );

    hexDecoder hexDecoder0 (
        .CLK      (CLK),
        .resetn   (resetn),
        .rxByte   (rxByte),
        .hexEnable(hexEnable),
        .hexByte  (hexByte)
    );

    wordAssembler wordAssembler0 (
        .CLK       (CLK),
        .resetn    (resetn),
        .binByte   (binByte),
        .hexByte   (hexByte),
        .frameStart(frameStart),
        .cfgWord   (cfgWord)
    );

endmodule

//--- tests/serialTasks.svh
// serial line driving, every task is entered and left on a falling clock edge

logic [31:0] lfsrState = 32'h7101;

// galois lfsr, one step for every bit handed out
function automatic int randomBits(input int count);
    int value;
    int i;
    value = 0;
    for (i = 0; i < count; i++) begin
        value = (value << 1) | int'(lfsrState[0]);
        if (lfsrState[0]) begin
            lfsrState = (lfsrState >> 1) ^ 32'h80200003;  // taps 32 22 2 1
        end else begin
            lfsrState = lfsrState >> 1;
        end
    end
    return value;
endfunction

task automatic holdLine(input logic level, input int cycles);
    rx = level;
    repeat (cycles) @(negedge CLK);
endtask

task automatic idleLine(input int cycles);
    holdLine(1'b1, cycles);
endtask

// one 8N1 frame, lsb first
task automatic sendByte(input logic [7:0] value);
    int i;
    holdLine(1'b0, clocksPerBit);  // start bit
    for (i = 0; i < 8; i++) begin
        holdLine(value[i], clocksPerBit);
    end
    holdLine(1'b1, clocksPerBit);  // stop bit
endtask

//--- tests/cfgUartTb.sv
module cfgUartTb;
    timeunit 1ns;
    timeprecision 1ps;
    import uartPkg::*;
    import loaderPkg::*;

    localparam int clocksPerBit  = 16;
    localparam int timeoutCycles = 2000;
    localparam int maxRandomGap  = 31;  // five lfsr bits per gap

    typedef enum logic [1:0] {opByte, opGap, opExpect, opState} opKindT;

    logic    CLK = 1'b0;
    logic    resetn;
    logic    rx;
    cfgWordT cfgWord;
    byteT    command;
    logic    comActive;

    opKindT      opKind[$];
    logic [31:0] opArg[$];
    logic [31:0] gotWords[$];
    logic [31:0] wantWords[$];
    int          byteTotal = 0;
    int          gapTotal = 0;
    longint      runLimit = 0;
    longint      cycleCount = 0;

    `include "serialTasks.svh"

    cfgUartTop #(
        .clocksPerBit (clocksPerBit),
        .timeoutCycles(timeoutCycles)
    ) dut0 (
        .CLK      (CLK),
        .resetn   (resetn),
        .rx       (rx),
        .cfgWord  (cfgWord),
        .command  (command),
        .comActive(comActive)
    );

    always #5 CLK = ~CLK;

    always @(posedge CLK) begin
        cycleCount <= cycleCount + 1;
        if (runLimit > 0 && cycleCount > runLimit) begin
            failRun($sformatf("run timed out after %0d clock cycles", cycleCount));
        end
    end

    // word monitor, strobe is a full cycle wide
    always @(negedge CLK) begin
        if (cfgWord.strobe) begin
            gotWords.push_back(cfgWord.data);
        end
    end

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic expectEqual(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            failRun($sformatf("mismatch at %0d ns: %s is %h, expected %h",
                              $time, name, got, want));
        end
    endtask

    // words seen since the last check against the expected list
    task automatic checkWords();
        int k;
        expectEqual("cfgWord count", gotWords.size(), wantWords.size());
        for (k = 0; k < wantWords.size(); k++) begin
            expectEqual("cfgWord.data", gotWords[k], wantWords[k]);
        end
        expectEqual("comActive", comActive, 1'b0);  // timeout has passed
        gotWords.delete();
        wantWords.delete();
    endtask

    task automatic readStimulus();
        int    fd;
        int    i;
        string line;
        string token;
        string tokens[$];
        fd = $fopen("tests/loaderStimulus.txt", "r");
        if (fd == 0) begin
            failRun("could not open the stimulus file tests/loaderStimulus.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            token = "";
            tokens.delete();
            for (i = 0; i < line.len(); i++) begin
                if (line[i] == " " || line[i] == "\n" || line[i] == "\r" || line[i] == "\t") begin
                    if (token.len() > 0) begin
                        tokens.push_back(token);
                    end
                    token = "";
                end else begin
                    token = {token, line.substr(i, i)};
                end
            end
            if (token.len() > 0) begin
                tokens.push_back(token);
            end
            if (tokens.size() == 0 || tokens[0].substr(0, 0) == "#") begin
                continue;
            end
            case (tokens[0])
                "F": begin
                    for (i = 1; i < tokens.size(); i++) begin
                        opKind.push_back(opByte);
                        opArg.push_back(tokens[i].atohex());
                        byteTotal++;
                    end
                end
                "G": begin
                    opKind.push_back(opGap);
                    opArg.push_back(tokens[1].atoi());
                    gapTotal += tokens[1].atoi();
                end
                "E": begin
                    opKind.push_back(opExpect);
                    opArg.push_back(tokens[1].atohex());
                end
                "S": begin
                    opKind.push_back(opState);
                    opArg.push_back((tokens[1].atoi() << 8) | tokens[2].atohex());
                end
                default: failRun({"unknown line in the stimulus file: ", line});
            endcase
        end
        $fclose(fd);
    endtask

    initial begin
        int k;
        resetn = 1'b0;
        rx     = 1'b1;
        readStimulus();
        runLimit = 2 * (byteTotal * (10 * clocksPerBit + maxRandomGap) + gapTotal + 4);
        repeat (4) @(negedge CLK);
        resetn = 1'b1;
        expectEqual("cfgWord.strobe", cfgWord.strobe, 1'b0);
        expectEqual("cfgWord.data", cfgWord.data, 32'h0);
        expectEqual("comActive", comActive, 1'b0);
        expectEqual("command", command, 8'h00);
        for (k = 0; k < opKind.size(); k++) begin
            case (opKind[k])
                opByte: begin
                    idleLine(randomBits(5));
                    sendByte(opArg[k][7:0]);
                end
                opGap: begin
                    idleLine(opArg[k]);
                    if (opArg[k] > timeoutCycles) begin
                        checkWords();
                    end
                end
                opExpect: wantWords.push_back(opArg[k]);
                default: begin  // state right after the last frame byte
                    expectEqual("comActive", comActive, opArg[k][8]);
                    expectEqual("command", command, opArg[k][7:0]);
                end
            endcase
        end
        $display("Everything OK");
        $finish;
    end

endmodule

//--- tests/loaderStimulus.txt
# F: frame bytes in hex | G: idle cycles, decimal | E: expected word in hex
# S: expected comActive and command after the last frame byte
F 00 AA FF 01 11 22 33 44 55 66 77 88
S 1 01
E 11223344
E 55667788
G 2500
F 00 AA FF 81 44 45 61 64 42 45 45 46 31 32 33 34 35 36 37 38
S 1 81
E DEADBEEF
E 12345678
G 2500
# the pair F x is broken and dropped
F 00 AA FF 82 31 32 43 41 46 78 45 31 35 35 30 66 31 45 20 32 64 33 63
S 1 82
E 12CAE155
E 0F1E2D3C
G 2500
F 00 AA FE 01
S 0 01
G 2500
F 00 AA FF 05
S 0 05
G 2500
F 00 AA
G 2500
F 00 AA FF 02 DE AD BE EF
S 1 02
E DEADBEEF
G 2500
# B1 B2 stay behind and must not reach the next frame
F 00 AA FF 01 A1 A2 A3 A4 B1 B2
S 1 01
E A1A2A3A4
G 2500
F 00 AA FF 81 43 30 46 46 45 45 30 30
S 1 81
E C0FFEE00
G 2500

//--- files.f
+incdir+tests
design/uartPkg.sv
design/loaderPkg.sv
design/uartRx.sv
design/loaderControl.sv
design/hexDecoder.sv
design/wordAssembler.sv
design/cfgUartTop.sv
tests/cfgUartTb.sv

//--- Bender.yml
package:
  name: cfg_uart_loader

sources:
  - design/uartPkg.sv
  - design/loaderPkg.sv
  - design/uartRx.sv
  - design/loaderControl.sv
  - design/hexDecoder.sv
  - design/wordAssembler.sv
  - design/cfgUartTop.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/cfgUartTb.sv
